/* include/camera_defines.svh */
`ifndef CAMERA_DEFINES_SVH
`define CAMERA_DEFINES_SVH

// ==============================
// Pixel and coordinate widths
// ==============================

// Raw sensor sample and colour channel width
`define PIXEL_WIDTH 12

// Column and row counters
`define COORD_WIDTH 16

`define FRAME_COUNT_WIDTH 16

// ==============================
// Buffer depth and tone defaults
// ==============================

// Longest line the demosaic line buffer holds
`define MAX_LINE_WIDTH 640

// Half scale for a 12-bit channel
`define DEFAULT_THRESHOLD 12'h800

`endif

/* hdl/cameraPkg.sv */
`default_nettype none

package cameraPkg;

	// ==============================
	// Capture control
	// ==============================

	// Capture FSM states
	typedef enum logic [1:0]
	{
		IDLE       = 2'd0,
		WAIT_FRAME = 2'd1,
		ACTIVE     = 2'd2,
		DRAINING   = 2'd3
	} captureState;

	// ==============================
	// Tone stage
	// ==============================

	// Output modes where code 3 falls back to colour
	typedef enum logic [1:0]
	{
		COLOR  = 2'd0,
		GRAY   = 2'd1,
		BINARY = 2'd2
	} toneMode;

endpackage

`default_nettype wire

/* hdl/pixelStreamIf.sv */
`timescale 1ns/100ps
`default_nettype none

`include "camera_defines.svh"

// Raw Bayer pixels with their frame position
interface rawStreamIf;
	logic [`PIXEL_WIDTH-1:0] data;
	logic valid;
	logic [`COORD_WIDTH-1:0] x;
	logic [`COORD_WIDTH-1:0] y;

	modport source (output data, output valid, output x, output y);
	modport sink (input data, input valid, input x, input y);
endinterface

// One RGB pixel per Bayer block
interface rgbStreamIf;
	logic [`PIXEL_WIDTH-1:0] red;
	logic [`PIXEL_WIDTH-1:0] green;
	logic [`PIXEL_WIDTH-1:0] blue;
	logic valid;

	modport source (output red, output green, output blue, output valid);
	modport sink (input red, input green, input blue, input valid);
endinterface

`default_nettype wire

/* hdl/frameCapture.sv */
`timescale 1ns/100ps
`default_nettype none

`include "camera_defines.svh"

module frameCapture import cameraPkg::*;
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input logic [`PIXEL_WIDTH-1:0] sensorData,
	input logic frameValid,
	input logic lineValid,
	input logic start,
	input logic stop,
	rawStreamIf.source raw,
	output logic frameStart,
	output logic [`FRAME_COUNT_WIDTH-1:0] frameCount
);

	logic [`PIXEL_WIDTH-1:0] dataReg;
	logic fvalReg;
	logic lvalReg;
	logic fvalPrev;
	logic lvalPrev;
	logic fvalRise;
	logic fvalFall;
	logic lineEnd;
	logic capture;
	logic [`COORD_WIDTH-1:0] xCount;
	logic [`COORD_WIDTH-1:0] yCount;
	captureState state;

	// ==============================
	// Sensor input registers
	// ==============================

	always_ff @(posedge D5M_PIXLCLK)
	begin
		dataReg <= sensorData;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			fvalReg <= 1'b0;
			lvalReg <= 1'b0;
			fvalPrev <= 1'b0;
			lvalPrev <= 1'b0;
		end
		else
		begin
			fvalReg <= frameValid;
			lvalReg <= lineValid;
			fvalPrev <= fvalReg;
			lvalPrev <= lvalReg;
		end
	end

	assign fvalRise = fvalReg && !fvalPrev;
	assign fvalFall = !fvalReg && fvalPrev;
	assign lineEnd = !lvalReg && lvalPrev;
	assign capture = ((state == ACTIVE) || (state == DRAINING)) && fvalReg && lvalReg;

	// ==============================
	// Capture FSM
	// ==============================

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			state <= IDLE;
			frameStart <= 1'b0;
			frameCount <= '0;
		end
		else
		begin
			frameStart <= 1'b0;
			case (state)
				IDLE:
				begin
					if (start)
						state <= WAIT_FRAME;
				end
				WAIT_FRAME:
				begin
					if (stop)
						state <= IDLE;
					else if (fvalRise)
					begin
						state <= ACTIVE;
						frameStart <= 1'b1;
					end
				end
				ACTIVE:
				begin
					// Back to back frames keep running until a stop
					if (fvalRise)
						frameStart <= 1'b1;
					// Stop between frames has nothing left to finish
					if (stop)
						state <= fvalReg ? DRAINING : IDLE;
				end
				DRAINING:
				begin
					if (fvalFall)
						state <= IDLE;
				end
				default:
					state <= IDLE;
			endcase
			if (fvalFall && ((state == ACTIVE) || (state == DRAINING)))
				frameCount <= frameCount + 1'b1;
		end
	end

	// Column and row positions of captured pixels
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			xCount <= '0;
			yCount <= '0;
		end
		else if (fvalRise)
		begin
			xCount <= '0;
			yCount <= '0;
		end
		else if (capture)
			xCount <= xCount + 1'b1;
		else if (lineEnd && (xCount != '0))
		begin
			xCount <= '0;
			yCount <= yCount + 1'b1;
		end
	end

	// ==============================
	// Output register
	// ==============================

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
			raw.valid <= 1'b0;
		else
			raw.valid <= capture;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (capture)
		begin
			raw.data <= dataReg;
			raw.x <= xCount;
			raw.y <= yCount;
		end
	end

endmodule

`default_nettype wire

/* hdl/bayerToRgb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "camera_defines.svh"

module bayerToRgb import cameraPkg::*;
#(
	parameter int lineWidth = `MAX_LINE_WIDTH
)
(
	input logic D5M_PIXLCLK,
	input logic rst,
	rawStreamIf.sink raw,
	rgbStreamIf.source rgb
);

	localparam int addrWidth = $clog2(lineWidth);

	// Even row of the current block pair, indexed by column
	logic [`PIXEL_WIDTH-1:0] lineBuf [lineWidth];

	// Previous pixel of the row being received
	logic [`PIXEL_WIDTH-1:0] prevPixel;

	logic [addrWidth-1:0] curAddr;
	logic [addrWidth-1:0] leftAddr;
	logic [`PIXEL_WIDTH-1:0] evenLeft;
	logic [`PIXEL_WIDTH-1:0] evenRight;
	logic [`PIXEL_WIDTH:0] greenSum;
	logic blockDone;

	// ==============================
	// Block assembly
	// ==============================

	assign curAddr = raw.x[addrWidth-1:0];
	assign leftAddr = curAddr - 1'b1;

	// Even row holds first green then red
	assign evenLeft = lineBuf[leftAddr];
	assign evenRight = lineBuf[curAddr];

	// Odd row pixel at an odd column is the second green
	assign greenSum = {1'b0, evenLeft} + {1'b0, raw.data};

	// Bottom right pixel closes the 2x2 block
	assign blockDone = raw.valid && raw.x[0] && raw.y[0];

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (raw.valid && !raw.y[0])
			lineBuf[curAddr] <= raw.data;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (raw.valid)
			prevPixel <= raw.data;
	end

	// ==============================
	// RGB output register
	// ==============================

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
			rgb.valid <= 1'b0;
		else
			rgb.valid <= blockDone;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (blockDone)
		begin
			rgb.red <= evenRight;
			// Blue sits at the even column of the odd row
			rgb.blue <= prevPixel;
			rgb.green <= greenSum[`PIXEL_WIDTH:1];
		end
	end

endmodule

`default_nettype wire

/* hdl/toneConfig.sv */
`timescale 1ns/100ps
`default_nettype none

`include "camera_defines.svh"

module toneConfig import cameraPkg::*;
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input toneMode mode,
	input logic [`PIXEL_WIDTH-1:0] threshold,
	input logic frameStart,
	output toneMode activeMode,
	output logic [`PIXEL_WIDTH-1:0] activeThreshold
);

	// Settings change only between frames, so one frame never mixes two modes
	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
		begin
			activeMode <= COLOR;
			activeThreshold <= `DEFAULT_THRESHOLD;
		end
		else if (frameStart)
		begin
			activeMode <= mode;
			activeThreshold <= threshold;
		end
	end

endmodule

`default_nettype wire

/* hdl/pixelTone.sv */
`timescale 1ns/100ps
`default_nettype none

`include "camera_defines.svh"

module pixelTone import cameraPkg::*;
(
	input logic D5M_PIXLCLK,
	input logic rst,
	rgbStreamIf.sink rgb,
	input toneMode activeMode,
	input logic [`PIXEL_WIDTH-1:0] activeThreshold,
	output logic [`PIXEL_WIDTH-1:0] red,
	output logic [`PIXEL_WIDTH-1:0] green,
	output logic [`PIXEL_WIDTH-1:0] blue,
	output logic pixelValid
);

	logic [`PIXEL_WIDTH+1:0] graySum;
	logic [`PIXEL_WIDTH-1:0] redD;
	logic [`PIXEL_WIDTH-1:0] greenD;
	logic [`PIXEL_WIDTH-1:0] blueD;
	logic [`PIXEL_WIDTH-1:0] grayD;
	logic [`PIXEL_WIDTH-1:0] binary;
	logic validD;

	// ==============================
	// Gray value stage
	// ==============================

	// (r + 2g + b) / 4 with two extra bits for the carry
	assign graySum = {2'b00, rgb.red} + {1'b0, rgb.green, 1'b0} + {2'b00, rgb.blue};

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
			validD <= 1'b0;
		else
			validD <= rgb.valid;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		redD <= rgb.red;
		greenD <= rgb.green;
		blueD <= rgb.blue;
		grayD <= graySum[`PIXEL_WIDTH+1:2];
	end

	// ==============================
	// Mode select stage
	// ==============================

	assign binary = (grayD >= activeThreshold) ? '1 : '0;

	always_ff @(posedge D5M_PIXLCLK)
	begin
		if (rst)
			pixelValid <= 1'b0;
		else
			pixelValid <= validD;
	end

	always_ff @(posedge D5M_PIXLCLK)
	begin
		case (activeMode)
			GRAY:
			begin
				red <= grayD;
				green <= grayD;
				blue <= grayD;
			end
			BINARY:
			begin
				red <= binary;
				green <= binary;
				blue <= binary;
			end
			// Unused code 3 shows colour as well
			default:
			begin
				red <= redD;
				green <= greenD;
				blue <= blueD;
			end
		endcase
	end

endmodule

`default_nettype wire

/* hdl/cameraPipeline.sv */
`timescale 1ns/100ps
`default_nettype none

`include "camera_defines.svh"

module cameraPipeline import cameraPkg::*;
(
	input logic D5M_PIXLCLK,
	input logic rst,
	input logic [`PIXEL_WIDTH-1:0] sensorData,
	input logic frameValid,
	input logic lineValid,
	input logic start,
	input logic stop,
	input toneMode mode,
	input logic [`PIXEL_WIDTH-1:0] threshold,
	output logic [`PIXEL_WIDTH-1:0] red,
	output logic [`PIXEL_WIDTH-1:0] green,
	output logic [`PIXEL_WIDTH-1:0] blue,
	output logic pixelValid,
	output logic [`FRAME_COUNT_WIDTH-1:0] frameCount
);

	rawStreamIf rawBus ();
	rgbStreamIf rgbBus ();

	logic frameStart;
	toneMode activeMode;
	logic [`PIXEL_WIDTH-1:0] activeThreshold;

	// Sensor capture and frame control
	frameCapture capture
	(
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.rst (rst),
		.sensorData (sensorData),
		.frameValid (frameValid),
		.lineValid (lineValid),
		.start (start),
		.stop (stop),
		.raw (rawBus.source),
		.frameStart (frameStart),
		.frameCount (frameCount)
	);

	bayerToRgb #(.lineWidth(`MAX_LINE_WIDTH)) demosaic
	(
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.rst (rst),
		.raw (rawBus.sink),
		.rgb (rgbBus.source)
	);

	// Tone settings latched per frame
	toneConfig settings
	(
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.rst (rst),
		.mode (mode),
		.threshold (threshold),
		.frameStart (frameStart),
		.activeMode (activeMode),
		.activeThreshold (activeThreshold)
	);

	pixelTone tone
	(
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.rst (rst),
		.rgb (rgbBus.sink),
		.activeMode (activeMode),
		.activeThreshold (activeThreshold),
		.red (red),
		.green (green),
		.blue (blue),
		.pixelValid (pixelValid)
	);

endmodule

`default_nettype wire

/* dv/clockGen.sv */
`timescale 1ns/100ps
`default_nettype none

module clockGen
#(
	parameter int halfPeriod = 100,
	parameter int resetCycles = 5
)
(
	output logic D5M_PIXLCLK,
	output logic rst
);

	initial
	begin
		D5M_PIXLCLK = 1'b0;
		forever
			#(halfPeriod) D5M_PIXLCLK = ~D5M_PIXLCLK;
	end

	// Reset drops on a rising edge after the hold
	initial
	begin
		rst = 1'b1;
		repeat (resetCycles) @(posedge D5M_PIXLCLK);
		rst <= 1'b0;
	end

endmodule

`default_nettype wire

/* dv/cameraPipelineTb.sv */
`timescale 1ns/100ps
`default_nettype none

`include "camera_defines.svh"

module cameraPipelineTb import cameraPkg::*;
();

	localparam int pw = `PIXEL_WIDTH;
	localparam int frameCols = 8;
	localparam int frameRows = 6;
	localparam int drainLimit = 200;

	logic D5M_PIXLCLK;
	logic rst;
	logic [pw-1:0] sensorData;
	logic frameValid;
	logic lineValid;
	logic start;
	logic stop;
	toneMode mode;
	logic [pw-1:0] threshold;
	logic [pw-1:0] red;
	logic [pw-1:0] green;
	logic [pw-1:0] blue;
	logic pixelValid;
	logic [`FRAME_COUNT_WIDTH-1:0] frameCount;

	int seed = 11368;
	logic [pw-1:0] pix [frameRows][frameCols];
	logic [3*pw-1:0] expQ [$];
	logic [3*pw-1:0] expPix;
	int expCount;
	bit running;
	toneMode curMode;
	logic [pw-1:0] curThr;

	clockGen clocks
	(
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.rst (rst)
	);

	cameraPipeline dut
	(
		.D5M_PIXLCLK (D5M_PIXLCLK),
		.rst (rst),
		.sensorData (sensorData),
		.frameValid (frameValid),
		.lineValid (lineValid),
		.start (start),
		.stop (stop),
		.mode (mode),
		.threshold (threshold),
		.red (red),
		.green (green),
		.blue (blue),
		.pixelValid (pixelValid),
		.frameCount (frameCount)
	);

	task automatic failRun(input string why);
		$display("%s", why);
		$display("Something failed");
		$fatal(1, "stopping at the first error");
	endtask

	// ==============================
	// Reference model
	// ==============================

	task automatic fillFrame();
		int rnd;
		for (int r = 0; r < frameRows; r++)
			for (int c = 0; c < frameCols; c++)
			begin
				rnd = $random(seed);
				pix[r][c] = rnd[pw-1:0];
			end
	endtask

	// One expected pixel per 2x2 block, in raster order of blocks
	task automatic pushFrame(input toneMode m, input logic [pw-1:0] thr);
		int rv;
		int gv;
		int bv;
		int grayv;
		logic [pw-1:0] binv;
		for (int by = 0; by < frameRows / 2; by++)
			for (int bx = 0; bx < frameCols / 2; bx++)
			begin
				rv = pix[2*by][2*bx+1];
				bv = pix[2*by+1][2*bx];
				gv = (pix[2*by][2*bx] + pix[2*by+1][2*bx+1]) / 2;
				grayv = (rv + 2 * gv + bv) / 4;
				binv = (grayv >= thr) ? {pw{1'b1}} : '0;
				if (m == GRAY)
					expQ.push_back({grayv[pw-1:0], grayv[pw-1:0], grayv[pw-1:0]});
				else if (m == BINARY)
					expQ.push_back({binv, binv, binv});
				else
					expQ.push_back({rv[pw-1:0], gv[pw-1:0], bv[pw-1:0]});
			end
	endtask

	// ==============================
	// Stimulus
	// ==============================

	task automatic setTone(input toneMode m, input logic [pw-1:0] thr);
		@(posedge D5M_PIXLCLK);
		mode <= m;
		threshold <= thr;
		curMode = m;
		curThr = thr;
	endtask

	task automatic pulseStart();
		@(posedge D5M_PIXLCLK);
		start <= 1'b1;
		@(posedge D5M_PIXLCLK);
		start <= 1'b0;
		running = 1'b1;
	endtask

	// Optional stop or mode change in the gap after row 2
	task automatic driveFrame(input bit stopMid, input bit changeMid, input toneMode newMode);
		@(posedge D5M_PIXLCLK);
		frameValid <= 1'b1;
		repeat (2) @(posedge D5M_PIXLCLK);
		for (int r = 0; r < frameRows; r++)
		begin
			for (int c = 0; c < frameCols; c++)
			begin
				@(posedge D5M_PIXLCLK);
				lineValid <= 1'b1;
				sensorData <= pix[r][c];
			end
			@(posedge D5M_PIXLCLK);
			lineValid <= 1'b0;
			sensorData <= '0;
			if (r == 2 && stopMid)
				stop <= 1'b1;
			if (r == 2 && changeMid)
			begin
				mode <= newMode;
				curMode = newMode;
			end
			@(posedge D5M_PIXLCLK);
			stop <= 1'b0;
			@(posedge D5M_PIXLCLK);
		end
		frameValid <= 1'b0;
		repeat (6) @(posedge D5M_PIXLCLK);
	endtask

	task automatic waitDrain();
		int cycles;
		cycles = 0;
		while (expQ.size() != 0)
		begin
			@(posedge D5M_PIXLCLK);
			cycles++;
			if (cycles > drainLimit)
				failRun("timed out waiting for the pixel outputs of a frame");
		end
	endtask

	task automatic runFrame(input bit stopMid, input bit changeMid, input toneMode newMode);
		if (running)
		begin
			pushFrame(curMode, curThr);
			expCount++;
		end
		driveFrame(stopMid, changeMid, newMode);
		if (stopMid)
			running = 1'b0;
		waitDrain();
		assert (frameCount == expCount[`FRAME_COUNT_WIDTH-1:0])
		else
			failRun($sformatf("mismatch frameCount: got 0x%h, expected 0x%h",
				frameCount, expCount[`FRAME_COUNT_WIDTH-1:0]));
	endtask

	// ==============================
	// Scoreboard
	// ==============================

	always @(negedge D5M_PIXLCLK)
	begin
		if (!rst && pixelValid)
		begin
			if (expQ.size() == 0)
				failRun("pixelValid was high while no pixel was expected");
			else
			begin
				expPix = expQ.pop_front();
				assert (red == expPix[3*pw-1:2*pw])
				else
					failRun($sformatf("mismatch red: got 0x%h, expected 0x%h",
						red, expPix[3*pw-1:2*pw]));
				assert (green == expPix[2*pw-1:pw])
				else
					failRun($sformatf("mismatch green: got 0x%h, expected 0x%h",
						green, expPix[2*pw-1:pw]));
				assert (blue == expPix[pw-1:0])
				else
					failRun($sformatf("mismatch blue: got 0x%h, expected 0x%h",
						blue, expPix[pw-1:0]));
			end
		end
	end

	initial
	begin
		int cycles;
		sensorData <= '0;
		frameValid <= 1'b0;
		lineValid <= 1'b0;
		start <= 1'b0;
		stop <= 1'b0;
		mode <= COLOR;
		threshold <= `DEFAULT_THRESHOLD;
		curMode = COLOR;
		curThr = `DEFAULT_THRESHOLD;
		running = 1'b0;
		expCount = 0;
		cycles = 0;
		while (rst !== 1'b0)
		begin
			@(posedge D5M_PIXLCLK);
			cycles++;
			if (cycles > 20)
				failRun("timed out waiting for reset to be released");
		end

		// No start yet, so nothing is captured
		fillFrame();
		runFrame(1'b0, 1'b0, COLOR);

		setTone(COLOR, `DEFAULT_THRESHOLD);
		pulseStart();
		fillFrame();
		runFrame(1'b0, 1'b0, COLOR);
		fillFrame();
		runFrame(1'b0, 1'b0, COLOR);

		setTone(GRAY, `DEFAULT_THRESHOLD);
		fillFrame();
		runFrame(1'b0, 1'b0, COLOR);

		// Blocks at and just below the threshold
		setTone(BINARY, 12'h700);
		fillFrame();
		pix[0][0] = 12'h700;
		pix[0][1] = 12'h700;
		pix[1][0] = 12'h700;
		pix[1][1] = 12'h700;
		pix[0][2] = 12'h6FF;
		pix[0][3] = 12'h6FF;
		pix[1][2] = 12'h6FF;
		pix[1][3] = 12'h6FF;
		runFrame(1'b0, 1'b0, COLOR);

		// Mode switch mid frame takes effect on the next frame
		setTone(COLOR, 12'h700);
		fillFrame();
		runFrame(1'b0, 1'b1, GRAY);
		fillFrame();
		runFrame(1'b0, 1'b0, COLOR);

		// Stop mid frame, then a frame that must be ignored
		fillFrame();
		runFrame(1'b1, 1'b0, COLOR);
		fillFrame();
		runFrame(1'b0, 1'b0, COLOR);

		$display("Everything OK");
		$finish;
	end

endmodule

`default_nettype wire

/* src.f */
+incdir+include
hdl/cameraPkg.sv
hdl/pixelStreamIf.sv
hdl/frameCapture.sv
hdl/bayerToRgb.sv
hdl/toneConfig.sv
hdl/pixelTone.sv
hdl/cameraPipeline.sv
dv/clockGen.sv
dv/cameraPipelineTb.sv

/* run.sh */
#!/bin/sh
# Build and run the camera pipeline testbench with Verilator
rm -rf obj_dir build.log sim.log
verilator --binary --timing -f src.f --top-module cameraPipelineTb -o cameraSim \
	> build.log 2>&1 \
	&& ./obj_dir/cameraSim > sim.log 2>&1 \
	|| echo "Something failed" >> sim.log
if grep -q "Something failed" sim.log
then
	echo "FAIL (see build.log and sim.log)"
	exit 1
fi
echo "PASS"
exit 0
